/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_uart_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+verif
logic/uart_pkg.sv
logic/uart_apb_regs.sv
logic/uart_transmitter.sv
logic/uart_receiver.sv
logic/uart_top.sv
verif/tb_uart_top.sv

/* logic/uart_apb_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_apb_regs (
    input  wire                              clk,
    input  wire                              arst_n,

    input  wire                              psel,
    input  wire                              penable,
    input  wire                              pwrite,
    input  wire [uart_pkg::APB_ADDR_W-1:0]   paddr,
    input  wire [31:0]                       pwdata,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr,

    output logic [uart_pkg::DATA_W-1:0]      tx_data,
    output logic                             tx_valid,
    input  wire                              tx_ready,

    input  wire [uart_pkg::DATA_W-1:0]       rx_data,
    input  wire                              rx_valid,
    input  wire                              rx_frame_err
);

    logic                        access;
    logic                        hit_tx;
    logic                        hit_rx;
    logic                        hit_status;
    logic                        unmapped;
    logic                        tx_wr;
    logic                        rx_rd;
    logic                        status_rd;

    logic [uart_pkg::DATA_W-1:0] rx_hold;
    logic                        rx_full;
    logic                        overrun;
    logic                        frame_err;
    logic [31:0]                 status_word;

    // Access phase of a zero wait state transfer
    assign access     = psel && penable;

    assign hit_tx     = (paddr == uart_pkg::ADDR_TX_DATA);
    assign hit_rx     = (paddr == uart_pkg::ADDR_RX_DATA);
    assign hit_status = (paddr == uart_pkg::ADDR_STATUS);
    assign unmapped   = !(hit_tx || hit_rx || hit_status);

    assign tx_wr      = access && pwrite && hit_tx;
    assign rx_rd      = access && !pwrite && hit_rx;
    assign status_rd  = access && !pwrite && hit_status;

    // Byte launch only when the transmitter can take it
    assign tx_valid   = tx_wr && tx_ready;
    assign tx_data    = pwdata[uart_pkg::DATA_W-1:0];

    assign pready     = 1'b1;
    assign pslverr    = access && (unmapped || (tx_wr && !tx_ready));

    always_comb begin
        status_word = '0;
        status_word[uart_pkg::ST_TX_READY]  = tx_ready;
        status_word[uart_pkg::ST_RX_FULL]   = rx_full;
        status_word[uart_pkg::ST_OVERRUN]   = overrun;
        status_word[uart_pkg::ST_FRAME_ERR] = frame_err;
    end

    always_comb begin
        prdata = '0;
        if (hit_rx) begin
            prdata[uart_pkg::DATA_W-1:0] = rx_hold;
        end else if (hit_status) begin
            prdata = status_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            rx_hold <= rx_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_full   <= 1'b0;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            // A new byte beats a read in the same cycle
            if (rx_valid) begin
                rx_full <= 1'b1;
            end else if (rx_rd) begin
                rx_full <= 1'b0;
            end

            if (rx_valid && rx_full) begin
                overrun <= 1'b1;
            end else if (status_rd) begin
                overrun <= 1'b0;
            end

            if (rx_frame_err) begin
                frame_err <= 1'b1;
            end else if (status_rd) begin
                frame_err <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // Width of one UART character
    localparam int DATA_W = 8;

    // APB byte address width
    localparam int APB_ADDR_W = 4;

    // Register map, byte offsets
    localparam logic [APB_ADDR_W-1:0] ADDR_TX_DATA = 4'h0;
    localparam logic [APB_ADDR_W-1:0] ADDR_RX_DATA = 4'h4;
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS  = 4'h8;

    // Status register bits
    localparam int ST_TX_READY  = 0;
    localparam int ST_RX_FULL   = 1;
    localparam int ST_OVERRUN   = 2;
    localparam int ST_FRAME_ERR = 3;

endpackage

`default_nettype wire

/* logic/uart_receiver.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_receiver #(
    parameter int CLOCK_FREQ = 125_000_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  wire                          clk,
    input  wire                          arst_n,

    input  wire                          serial_in,

    output logic [uart_pkg::DATA_W-1:0]  data_out,
    output logic                         data_out_valid,
    output logic                         frame_err
);

    localparam int BIT_TIME = CLOCK_FREQ / BAUD_RATE;
    localparam int CNT_W    = (BIT_TIME > 1) ? $clog2(BIT_TIME) : 1;
    localparam int BIDX_W   = $clog2(uart_pkg::DATA_W);

    localparam logic [CNT_W-1:0]  LAST_CNT  = CNT_W'(BIT_TIME - 1);
    localparam logic [CNT_W-1:0]  HALF_CNT  = CNT_W'(BIT_TIME / 2);
    localparam logic [BIDX_W-1:0] LAST_DATA = BIDX_W'(uart_pkg::DATA_W - 1);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t                       state;
    logic [1:0]                   sync_q;
    logic                         rx_s;
    logic                         rx_prev;
    logic [CNT_W-1:0]             clk_cnt;
    logic [BIDX_W-1:0]            bit_idx;
    logic [uart_pkg::DATA_W-1:0]  data_sr;
    logic                         start_mid;
    logic                         bit_mid;

    assign rx_s      = sync_q[1];
    assign start_mid = (state == START) && (clk_cnt == HALF_CNT);
    assign bit_mid   = (state == DATA || state == STOP) && (clk_cnt == LAST_CNT);

    assign data_out       = data_sr;
    assign data_out_valid = (state == STOP) && bit_mid && rx_s;
    assign frame_err      = (state == STOP) && bit_mid && !rx_s;

    // Line idles high, so the flops come out of reset high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q  <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            sync_q  <= {sync_q[0], serial_in};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // Edge cycle already counts as cycle zero of the start bit
                    if (rx_prev && !rx_s) begin
                        state   <= START;
                        clk_cnt <= CNT_W'(1);
                    end
                end
                START: begin
                    if (start_mid) begin
                        // Glitch if the line is high again by mid-bit
                        state   <= rx_s ? IDLE : DATA;
                        clk_cnt <= '0;
                        bit_idx <= '0;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_mid) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_DATA) begin
                            state <= STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_mid) begin
                        state   <= IDLE;
                        clk_cnt <= '0;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == DATA && bit_mid) begin
            data_sr <= {rx_s, data_sr[uart_pkg::DATA_W-1:1]};
        end
    end

endmodule

`default_nettype wire

/* logic/uart_top.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_top #(
    parameter int CLOCK_FREQ = 125_000_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  wire                             clk,
    input  wire                             arst_n,

    input  wire                             psel,
    input  wire                             penable,
    input  wire                             pwrite,
    input  wire [uart_pkg::APB_ADDR_W-1:0]  paddr,
    input  wire [31:0]                      pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,

    input  wire                             serial_in,
    output logic                            serial_out
);

    logic [uart_pkg::DATA_W-1:0] tx_data;
    logic                        tx_valid;
    logic                        tx_ready;
    logic [uart_pkg::DATA_W-1:0] rx_data;
    logic                        rx_valid;
    logic                        rx_frame_err;

    uart_apb_regs u_apb_regs (
        .clk          (clk),
        .arst_n       (arst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err)
    );

    uart_transmitter #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) u_transmitter (
        .clk           (clk),
        .arst_n        (arst_n),
        .data_in       (tx_data),
        .data_in_valid (tx_valid),
        .data_in_ready (tx_ready),
        .serial_out    (serial_out)
    );

    uart_receiver #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) u_receiver (
        .clk            (clk),
        .arst_n         (arst_n),
        .serial_in      (serial_in),
        .data_out       (rx_data),
        .data_out_valid (rx_valid),
        .frame_err      (rx_frame_err)
    );

endmodule

`default_nettype wire

/* logic/uart_transmitter.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_transmitter #(
    parameter int CLOCK_FREQ = 125_000_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  wire                          clk,
    input  wire                          arst_n,

    input  wire [uart_pkg::DATA_W-1:0]   data_in,
    input  wire                          data_in_valid,
    output logic                         data_in_ready,

    output logic                         serial_out
);

    localparam int BIT_TIME = CLOCK_FREQ / BAUD_RATE;
    localparam int CNT_W    = (BIT_TIME > 1) ? $clog2(BIT_TIME) : 1;
    localparam int FRAME_W  = uart_pkg::DATA_W + 2;
    localparam int BCNT_W   = $clog2(FRAME_W + 1);

    localparam logic [CNT_W-1:0]  LAST_CNT = CNT_W'(BIT_TIME - 1);
    localparam logic [BCNT_W-1:0] LAST_BIT = BCNT_W'(FRAME_W);

    typedef enum logic {
        IDLE,
        WORK
    } state_t;

    state_t              state;
    state_t              state_next;
    logic [FRAME_W-1:0]  shift_q;
    logic [CNT_W-1:0]    clk_cnt;
    logic [BCNT_W-1:0]   bit_cnt;
    logic                symbol_edge;
    logic                fire;

    assign symbol_edge   = (state == WORK) && (clk_cnt == LAST_CNT);
    assign fire          = data_in_valid && data_in_ready;
    assign data_in_ready = (state == IDLE);
    assign serial_out    = (state == WORK) ? shift_q[0] : 1'b1;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: if (data_in_valid) state_next = WORK;
            WORK: if (bit_cnt == LAST_BIT) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Frame goes out LSB first, ones fill in behind the stop bit
    always_ff @(posedge clk) begin
        if (fire) begin
            shift_q <= {1'b1, data_in, 1'b0};
        end else if (symbol_edge) begin
            shift_q <= {1'b1, shift_q[FRAME_W-1:1]};
        end
    end

    // Cycles within the current bit
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_cnt <= '0;
        end else if (state == IDLE || symbol_edge) begin
            clk_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Bits sent so far, stops at ten
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt <= '0;
        end else if (state == IDLE) begin
            bit_cnt <= '0;
        end else if (symbol_edge && bit_cnt < LAST_BIT) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verif/uart_tb_tasks.svh */
`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
        errors = errors + 1;
        $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
endtask

function automatic logic [31:0] expected_status(input logic tx_rdy, input logic rx_full,
                                                input logic ovr, input logic ferr);
    logic [31:0] word;
    word = '0;
    word[uart_pkg::ST_TX_READY]  = tx_rdy;
    word[uart_pkg::ST_RX_FULL]   = rx_full;
    word[uart_pkg::ST_OVERRUN]   = ovr;
    word[uart_pkg::ST_FRAME_ERR] = ferr;
    return word;
endfunction

// Setup cycle, access cycle, then bus idle; response sampled mid-access
task automatic apb_write(input logic [uart_pkg::APB_ADDR_W-1:0] addr, input logic [31:0] data,
                         output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    err = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
endtask

task automatic apb_read(input logic [uart_pkg::APB_ADDR_W-1:0] addr, output logic [31:0] data,
                        output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

task automatic wait_status(input int pos, input logic val, output logic [31:0] st);
    logic err;
    logic seen;
    int   n;
    seen = 1'b0;
    st   = '0;
    for (n = 0; n < POLL_LIMIT && !seen; n++) begin
        apb_read(uart_pkg::ADDR_STATUS, st, err);
        if (st[pos] == val) begin
            seen = 1'b1;
        end
    end
    if (!seen) begin
        errors = errors + 1;
        $display("Timed out waiting for status bit %0d to read %0d", pos, val);
    end
endtask

// Start bit, data LSB first, chosen stop bit
task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
        @(posedge clk);
        line_drv <= frame[i];
        repeat (BIT_CYC - 1) @(posedge clk);
    end
    @(posedge clk);
    line_drv <= 1'b1;
endtask

task automatic test_reset_state();
    logic [31:0] rd;
    logic        err;
    apb_read(uart_pkg::ADDR_STATUS, rd, err);
    check_value("prdata", rd, expected_status(1'b1, 1'b0, 1'b0, 1'b0));
    check_value("pslverr", 32'(err), 32'h0);
    @(negedge clk);
    check_value("pready", 32'(pready), 32'h1);
    check_value("serial_out", 32'(serial_out), 32'h1);
    apb_read(4'hC, rd, err);
    check_value("pslverr", 32'(err), 32'h1);
endtask

task automatic test_tx_frame();
    logic [7:0]  data;
    logic [31:0] rd;
    logic        err;
    logic        found;
    data = 8'($urandom);
    @(posedge clk);
    loopback <= 1'b0;
    apb_write(uart_pkg::ADDR_TX_DATA, {24'h0, data}, err);
    check_value("pslverr", 32'(err), 32'h0);
    found = 1'b0;
    for (int i = 0; i < 2 * BIT_CYC && !found; i++) begin
        @(negedge clk);
        if (!serial_out) begin
            found = 1'b1;
        end
    end
    if (!found) begin
        errors = errors + 1;
        $display("No start bit seen on serial_out after the TX_DATA write");
        return;
    end
    // Move from half a cycle in to the middle of the start bit
    repeat (BIT_CYC / 2 - 1) @(negedge clk);
    check_value("serial_out start", 32'(serial_out), 32'h0);
    for (int i = 0; i < 8; i++) begin
        repeat (BIT_CYC) @(negedge clk);
        check_value("serial_out data", 32'(serial_out), 32'(data[i]));
    end
    repeat (BIT_CYC) @(negedge clk);
    check_value("serial_out stop", 32'(serial_out), 32'h1);
    apb_read(uart_pkg::ADDR_STATUS, rd, err);
    check_value("status tx_ready", 32'(rd[uart_pkg::ST_TX_READY]), 32'h0);
    wait_status(uart_pkg::ST_TX_READY, 1'b1, rd);
    @(negedge clk);
    check_value("serial_out", 32'(serial_out), 32'h1);
endtask

task automatic test_loopback();
    logic [7:0]  data;
    logic [31:0] rd;
    logic        err;
    @(posedge clk);
    loopback <= 1'b1;
    for (int n = 0; n < N_LOOP_BYTES; n++) begin
        data = 8'($urandom);
        apb_write(uart_pkg::ADDR_TX_DATA, {24'h0, data}, err);
        check_value("pslverr", 32'(err), 32'h0);
        wait_status(uart_pkg::ST_RX_FULL, 1'b1, rd);
        apb_read(uart_pkg::ADDR_RX_DATA, rd, err);
        check_value("prdata", rd, {24'h0, data});
        apb_read(uart_pkg::ADDR_STATUS, rd, err);
        check_value("status rx_full", 32'(rd[uart_pkg::ST_RX_FULL]), 32'h0);
        wait_status(uart_pkg::ST_TX_READY, 1'b1, rd);
    end
endtask

task automatic test_busy_write();
    logic [7:0]  first;
    logic [7:0]  second;
    logic [31:0] rd;
    logic        err;
    first  = 8'($urandom);
    second = ~first;
    apb_write(uart_pkg::ADDR_TX_DATA, {24'h0, first}, err);
    check_value("pslverr", 32'(err), 32'h0);
    apb_write(uart_pkg::ADDR_TX_DATA, {24'h0, second}, err);
    check_value("pslverr", 32'(err), 32'h1);
    wait_status(uart_pkg::ST_RX_FULL, 1'b1, rd);
    apb_read(uart_pkg::ADDR_RX_DATA, rd, err);
    check_value("prdata", rd, {24'h0, first});
    wait_status(uart_pkg::ST_TX_READY, 1'b1, rd);
    // Long enough for a dropped byte to have shown up
    repeat (12 * BIT_CYC) @(posedge clk);
    apb_read(uart_pkg::ADDR_STATUS, rd, err);
    check_value("prdata", rd, expected_status(1'b1, 1'b0, 1'b0, 1'b0));
endtask

task automatic test_overrun();
    logic [7:0]  first;
    logic [7:0]  second;
    logic [31:0] rd;
    logic        err;
    first  = 8'($urandom);
    second = 8'($urandom);
    if (second == first) begin
        second = ~first;
    end
    apb_write(uart_pkg::ADDR_TX_DATA, {24'h0, first}, err);
    wait_status(uart_pkg::ST_RX_FULL, 1'b1, rd);
    wait_status(uart_pkg::ST_TX_READY, 1'b1, rd);
    apb_write(uart_pkg::ADDR_TX_DATA, {24'h0, second}, err);
    check_value("pslverr", 32'(err), 32'h0);
    wait_status(uart_pkg::ST_OVERRUN, 1'b1, rd);
    check_value("status rx_full", 32'(rd[uart_pkg::ST_RX_FULL]), 32'h1);
    // Polling read above clears overrun but leaves the held byte
    apb_read(uart_pkg::ADDR_STATUS, rd, err);
    check_value("status overrun", 32'(rd[uart_pkg::ST_OVERRUN]), 32'h0);
    check_value("status rx_full", 32'(rd[uart_pkg::ST_RX_FULL]), 32'h1);
    apb_read(uart_pkg::ADDR_RX_DATA, rd, err);
    check_value("prdata", rd, {24'h0, second});
    apb_read(uart_pkg::ADDR_STATUS, rd, err);
    check_value("status rx_full", 32'(rd[uart_pkg::ST_RX_FULL]), 32'h0);
    wait_status(uart_pkg::ST_TX_READY, 1'b1, rd);
endtask

task automatic test_frame_error();
    logic [31:0] rd;
    logic        err;
    @(posedge clk);
    loopback <= 1'b0;
    drive_frame(8'($urandom), 1'b0);
    repeat (4) @(posedge clk);
    apb_read(uart_pkg::ADDR_STATUS, rd, err);
    check_value("prdata", rd, expected_status(1'b1, 1'b0, 1'b0, 1'b1));
    // Sticky flag gone after the read
    apb_read(uart_pkg::ADDR_STATUS, rd, err);
    check_value("prdata", rd, expected_status(1'b1, 1'b0, 1'b0, 1'b0));
endtask

`endif

/* verif/tb_uart_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_uart_top;

    localparam int CLOCK_FREQ   = 50_000_000;
    localparam int BAUD_RATE    = 5_000_000;
    localparam int BIT_CYC      = CLOCK_FREQ / BAUD_RATE;
    localparam int CLK_PERIOD   = 20;
    localparam int SEED         = 77337;
    localparam int N_LOOP_BYTES = 4;
    localparam int POLL_LIMIT   = 60;

    // Frames sent over the whole run, with one spare
    localparam int NUM_FRAMES   = N_LOOP_BYTES + 6;
    localparam int WATCHDOG_NS  = NUM_FRAMES * 10 * BIT_CYC * CLK_PERIOD + 40_000;

    logic                            clk;
    logic                            arst_n;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [uart_pkg::APB_ADDR_W-1:0] paddr;
    logic [31:0]                     pwdata;
    logic [31:0]                     prdata;
    logic                            pready;
    logic                            pslverr;
    logic                            serial_in;
    logic                            serial_out;

    logic                            loopback;
    logic                            line_drv;
    int                              errors;
    int                              checks;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Receiver input comes from the transmitter or from the line driver
    assign serial_in = loopback ? serial_out : line_drv;

    uart_top #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) u_uart_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

    `include "uart_tb_tasks.svh"

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        errors   = 0;
        checks   = 0;
        arst_n   = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        loopback = 1'b0;
        line_drv = 1'b1;

        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        test_reset_state();
        test_tx_frame();
        test_loopback();
        test_busy_write();
        test_overrun();
        test_frame_error();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
